//--- hw/sw_pkg.sv
`default_nettype none

package sw_pkg;

	// array and buffer sizes
	localparam int NUM_PE    = 8;
	localparam int PE_LOG    = 4;
	localparam int MAX_T     = 64;
	localparam int MAX_T_LOG = 7;

	// score and external scoring input widths
	localparam int SCORE_W = 10;
	localparam int PEN_W   = 4;

	// 2-bit nucleotide code
	typedef logic [1:0] base_t;
	typedef logic signed [SCORE_W-1:0] score_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD_T,
		CALC,
		DRAIN
	} ctrl_state_e;

	function automatic score_t smax(score_t a, score_t b);
		return (a > b) ? a : b;
	endfunction

	// unsigned penalty magnitude to a negative score
	function automatic score_t neg_pen(logic [PEN_W-1:0] p);
		score_t m;
		m = score_t'({{(SCORE_W-PEN_W){1'b0}}, p});
		return -m;
	endfunction

endpackage

`default_nettype wire

//--- hw/t_stream_if.sv
`timescale 1ns/1ns
`default_nettype none

interface t_stream_if import sw_pkg::*; (
	input logic clk
);
	base_t t_base;
	logic  t_valid;
	logic  t_first;
	logic  t_last;

	// buffer side, one base per cycle, no gaps
	modport feeder (
		input  clk,
		output t_base, t_valid, t_first, t_last
	);

	// no back-pressure from the array
	modport array (
		input clk,
		input t_base, t_valid, t_first, t_last
	);

endinterface

`default_nettype wire

//--- hw/t_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module t_buffer import sw_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_load_start,
	input  logic                 i_t_valid,
	input  logic                 i_t_last,
	input  base_t                i_t,
	input  logic                 i_stream_start,
	output logic [MAX_T_LOG-1:0] o_t_len,
	output logic                 o_loading,
	t_stream_if.feeder           t_out
);
	base_t mem [MAX_T];
	logic [MAX_T_LOG-1:0] wptr;
	logic [MAX_T_LOG-1:0] rptr;
	logic wr_en;
	logic streaming;
	logic last_base;

	// bases past MAX_T are dropped
	assign wr_en = o_loading && i_t_valid && (wptr != MAX_T_LOG'(MAX_T));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			o_loading <= 1'b0;
		end else if (i_load_start) begin
			wptr <= '0;
			o_loading <= 1'b1;
		end else if (o_loading) begin
			if (wr_en) begin
				wptr <= wptr + 1'b1;
			end
			if (i_t_last) begin
				o_loading <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wptr[MAX_T_LOG-2:0]] <= i_t;
		end
	end

	// stored length is the final write pointer
	assign o_t_len = wptr;

	assign last_base = streaming && (rptr == wptr - 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			streaming <= 1'b0;
			rptr <= '0;
		end else if (i_stream_start) begin
			streaming <= (wptr != '0);
			rptr <= '0;
		end else if (streaming) begin
			rptr <= rptr + 1'b1;
			if (last_base) begin
				streaming <= 1'b0;
			end
		end
	end

	assign t_out.t_valid = streaming;
	assign t_out.t_base  = streaming ? mem[rptr[MAX_T_LOG-2:0]] : base_t'(0);
	assign t_out.t_first = streaming && (rptr == '0);
	assign t_out.t_last  = last_base;

endmodule

`default_nettype wire

//--- hw/pe_cell.sv
`timescale 1ns/1ns
`default_nettype none

module pe_cell import sw_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_clear,
	input  logic   i_en,
	input  base_t  i_q_base,
	input  base_t  i_t_base,
	input  score_t i_h_diag,
	input  score_t i_h_left,
	input  score_t i_e_left,
	input  score_t i_match,
	input  score_t i_mismatch,
	input  score_t i_open,
	input  score_t i_extend,
	output score_t o_h,
	output score_t o_e,
	output base_t  o_t_base
);
	score_t f_q;
	score_t h_up;
	score_t f_up;
	score_t diag;
	score_t e_nx;
	score_t f_nx;
	score_t h_nx;

	// penalties arrive already negative, so everything is an add
	always_comb begin
		// first base of a run sees an all-zero row above
		h_up = i_clear ? score_t'(0) : o_h;
		f_up = i_clear ? score_t'(0) : f_q;
		diag = i_clear ? score_t'(0) : i_h_diag;

		// gap in the query, carried along the chain
		e_nx = smax(i_h_left + i_open, i_e_left + i_extend);
		// gap in the target, kept in this cell
		f_nx = smax(h_up + i_open, f_up + i_extend);

		h_nx = diag + ((i_q_base == i_t_base) ? i_match : i_mismatch);
		h_nx = smax(h_nx, smax(e_nx, f_nx));
		h_nx = smax(h_nx, score_t'(0));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_h <= '0;
			o_e <= '0;
			f_q <= '0;
		end else if (i_en) begin
			o_h <= h_nx;
			o_e <= e_nx;
			f_q <= f_nx;
		end
	end

	always_ff @(posedge clk) begin
		if (i_en) begin
			o_t_base <= i_t_base;
		end
	end

endmodule

`default_nettype wire

//--- hw/pe_array.sv
`timescale 1ns/1ns
`default_nettype none

module pe_array import sw_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_start,
	input  logic [2*NUM_PE-1:0]   i_s,
	input  logic [PE_LOG-1:0]     i_s_len,
	input  score_t                i_match,
	input  score_t                i_mismatch,
	input  score_t                i_open,
	input  score_t                i_extend,
	t_stream_if.array             t_in,
	output score_t                o_result,
	output logic                  o_valid
);
	logic [2*NUM_PE-1:0] q_q;
	logic [PE_LOG-1:0] len_q;

	// flags entering and leaving each cell
	logic [NUM_PE-1:0] v_in, f_in, l_in;
	logic [NUM_PE-1:0] v_out, f_out, l_out;

	score_t h [NUM_PE];
	score_t e [NUM_PE];
	base_t  tb [NUM_PE];
	score_t max_q;
	score_t best;

	always_ff @(posedge clk) begin
		if (i_start) begin
			q_q <= i_s;
			len_q <= i_s_len;
		end
	end

	assign v_in = {v_out[NUM_PE-2:0], t_in.t_valid};
	assign f_in = {f_out[NUM_PE-2:0], t_in.t_first};
	assign l_in = {l_out[NUM_PE-2:0], t_in.t_last};

	// flags move one cell per cycle with their base
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v_out <= '0;
			f_out <= '0;
			l_out <= '0;
		end else begin
			v_out <= v_in;
			f_out <= f_in;
			l_out <= l_in;
		end
	end

	for (genvar j = 0; j < NUM_PE; j++) begin : g_pe
		score_t h_left;
		score_t e_left;
		score_t h_diag;
		base_t  b_in;

		if (j == 0) begin : g_head
			assign h_left = '0;
			assign e_left = '0;
			assign h_diag = '0;
			assign b_in = t_in.t_base;
		end else begin : g_body
			score_t diag_q;

			// left neighbour's H one step back
			always_ff @(posedge clk) begin
				if (v_in[j]) begin
					diag_q <= h[j-1];
				end
			end

			assign h_left = h[j-1];
			assign e_left = e[j-1];
			assign h_diag = diag_q;
			assign b_in = tb[j-1];
		end

		pe_cell u_cell (
			.clk       (clk),
			.rst_n     (rst_n),
			.i_clear   (f_in[j]),
			.i_en      (v_in[j]),
			.i_q_base  (q_q[2*j +: 2]),
			.i_t_base  (b_in),
			.i_h_diag  (h_diag),
			.i_h_left  (h_left),
			.i_e_left  (e_left),
			.i_match   (i_match),
			.i_mismatch(i_mismatch),
			.i_open    (i_open),
			.i_extend  (i_extend),
			.o_h       (h[j]),
			.o_e       (e[j]),
			.o_t_base  (tb[j])
		);
	end

	// cells past the query length are left out of the maximum
	always_comb begin
		best = max_q;
		for (int j = 0; j < NUM_PE; j++) begin
			if (v_out[j] && (PE_LOG'(j) < len_q)) begin
				best = smax(best, h[j]);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			max_q <= '0;
			o_valid <= 1'b0;
		end else begin
			max_q <= i_start ? score_t'(0) : best;
			o_valid <= l_out[NUM_PE-1];
		end
	end

	assign o_result = max_q;

endmodule

`default_nettype wire

//--- hw/sw_top.sv
`timescale 1ns/1ns
`default_nettype none

module sw_top import sw_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_set_t,
	input  base_t               i_t,
	input  logic                i_t_valid,
	input  logic                i_t_last,
	input  logic                i_start_cal,
	input  logic [2*NUM_PE-1:0] i_s,
	input  logic [PE_LOG-1:0]   i_s_len,
	input  logic [PEN_W-1:0]    i_match,
	input  logic [PEN_W-1:0]    i_mismatch,
	input  logic [PEN_W-1:0]    i_minus_alpha,
	input  logic [PEN_W-1:0]    i_minus_beta,
	output logic                o_busy,
	output score_t              o_result,
	output logic                o_valid
);
	// registered inputs
	logic set_r, start_r, t_valid_r, t_last_r;
	base_t t_r;
	logic [2*NUM_PE-1:0] s_r;
	logic [PE_LOG-1:0] s_len_r;
	logic [PEN_W-1:0] match_r, mismatch_r, alpha_r, beta_r;

	ctrl_state_e state, state_nx;
	logic load_start, cal_start, stream_start;
	logic [MAX_T_LOG-1:0] t_len;
	logic loading;

	score_t pen_match, pen_mismatch, pen_open, pen_extend;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			set_r <= 1'b0;
			start_r <= 1'b0;
			t_valid_r <= 1'b0;
			t_last_r <= 1'b0;
		end else begin
			set_r <= i_set_t;
			start_r <= i_start_cal;
			t_valid_r <= i_t_valid;
			t_last_r <= i_t_last;
		end
	end

	always_ff @(posedge clk) begin
		t_r <= i_t;
		s_r <= i_s;
		s_len_r <= i_s_len;
		match_r <= i_match;
		mismatch_r <= i_mismatch;
		alpha_r <= i_minus_alpha;
		beta_r <= i_minus_beta;
	end

	// set and start only count in IDLE
	always_comb begin
		state_nx = state;
		load_start = 1'b0;
		cal_start = 1'b0;
		case (state)
			IDLE: begin
				if (set_r) begin
					state_nx = LOAD_T;
					load_start = 1'b1;
				end else if (start_r && (t_len != '0)) begin
					state_nx = CALC;
					cal_start = 1'b1;
				end
			end
			LOAD_T: begin
				if (!loading) begin
					state_nx = IDLE;
				end
			end
			CALC: begin
				if (o_valid) begin
					state_nx = DRAIN;
				end
			end
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			stream_start <= 1'b0;
		end else begin
			state <= state_nx;
			stream_start <= cal_start;
		end
	end

	assign o_busy = (state != IDLE);

	// frozen for the whole run
	always_ff @(posedge clk) begin
		if (state != CALC) begin
			pen_match <= score_t'({{(SCORE_W-PEN_W){1'b0}}, match_r});
			pen_mismatch <= neg_pen(mismatch_r);
			pen_open <= neg_pen(alpha_r);
			pen_extend <= neg_pen(beta_r);
		end
	end

	t_stream_if t_if (.clk(clk));

	t_buffer u_buf (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_load_start  (load_start),
		.i_t_valid     (t_valid_r),
		.i_t_last      (t_last_r),
		.i_t           (t_r),
		.i_stream_start(stream_start),
		.o_t_len       (t_len),
		.o_loading     (loading),
		.t_out         (t_if)
	);

	pe_array u_array (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_start   (cal_start),
		.i_s       (s_r),
		.i_s_len   (s_len_r),
		.i_match   (pen_match),
		.i_mismatch(pen_mismatch),
		.i_open    (pen_open),
		.i_extend  (pen_extend),
		.t_in      (t_if),
		.o_result  (o_result),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

//--- test/sw_props.sv
`timescale 1ns/1ns
`default_nettype none

module sw_props import sw_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic        i_cal_start,
	input ctrl_state_e i_state,
	input logic        i_busy,
	input logic        i_valid
);
	logic in_run;

	// from the cycle after a start until the result pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_run <= 1'b0;
		end else if (i_cal_start) begin
			in_run <= 1'b1;
		end else if (i_valid) begin
			in_run <= 1'b0;
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) i_valid |=> !i_valid)
		else $error("o_valid held for more than one cycle");

	a_valid_in_calc: assert property (@(posedge clk) disable iff (!rst_n)
		i_valid |-> (i_state == CALC))
		else $error("o_valid raised outside CALC");

	a_busy_in_run: assert property (@(posedge clk) disable iff (!rst_n) in_run |-> i_busy)
		else $error("o_busy low while a calculation runs");

endmodule

bind sw_top sw_props u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_cal_start(cal_start),
	.i_state    (state),
	.i_busy     (o_busy),
	.i_valid    (o_valid)
);

`default_nettype wire

//--- test/sw_checker.sv
`timescale 1ns/1ns
`default_nettype none

module sw_checker import sw_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_valid,
	input  logic   i_busy,
	input  score_t i_result,
	input  logic   i_go,
	input  logic   i_none,
	input  int     i_idx,
	input  int     i_expected,
	input  int     i_bound,
	output int     o_done,
	output int     o_errors
);
	logic armed;
	logic none_q;
	int idx_q;
	int exp_q;
	int bound_q;
	int waited;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed <= 1'b0;
			none_q <= 1'b0;
			waited <= 0;
			o_done <= 0;
			o_errors <= 0;
		end else if (i_go) begin
			armed <= 1'b1;
			none_q <= i_none;
			idx_q <= i_idx;
			exp_q <= i_expected;
			bound_q <= i_bound;
			waited <= 0;
		end else if (armed) begin
			waited <= waited + 1;
			if (none_q) begin
				// empty buffer, the start must go unnoticed
				if (i_valid || i_busy) begin
					$display("test %0d: start with an empty target buffer was not ignored",
						idx_q);
					o_errors <= o_errors + 1;
					armed <= 1'b0;
					o_done <= o_done + 1;
				end else if (waited >= bound_q) begin
					$display("test %0d: ok, no result for an empty buffer", idx_q);
					armed <= 1'b0;
					o_done <= o_done + 1;
				end
			end else if (i_valid) begin
				if (i_result !== score_t'(exp_q)) begin
					$display("MISMATCH at %0t ns: o_result expected %0d, actual %0d (test %0d)",
						$time, exp_q, i_result, idx_q);
					o_errors <= o_errors + 1;
				end else begin
					$display("test %0d: ok, score %0d", idx_q, i_result);
				end
				armed <= 1'b0;
				o_done <= o_done + 1;
			end else if (waited >= bound_q) begin
				$display("test %0d: no o_valid pulse within %0d cycles", idx_q, bound_q);
				o_errors <= o_errors + 1;
				armed <= 1'b0;
				o_done <= o_done + 1;
			end
		end else if (i_valid) begin
			$display("%0t ns: o_valid pulse while no test was running", $time);
			o_errors <= o_errors + 1;
		end
	end

endmodule

`default_nettype wire

//--- test/sw_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sw_tb import sw_pkg::*; ();

	localparam int N_TABLE     = 8;
	localparam int N_RAND      = 12;
	localparam int N_TESTS     = N_TABLE + N_RAND + 1;
	localparam int CASE_CYCLES = 2 * (MAX_T + NUM_PE + 20);
	localparam int WATCHDOG_NS = (N_TESTS * CASE_CYCLES + 10) * 20;
	localparam int NEG_INF     = -1000;

	// bases are packed low first, A=0 C=1 G=2 T=3
	typedef struct packed {
		logic                 reload;
		logic                 pen_swap;
		logic [2*MAX_T-1:0]   tgt;
		logic [MAX_T_LOG-1:0] tlen;
		logic [2*NUM_PE-1:0]  q;
		logic [PE_LOG-1:0]    qlen;
		logic [PEN_W-1:0]     ma;
		logic [PEN_W-1:0]     mi;
		logic [PEN_W-1:0]     al;
		logic [PEN_W-1:0]     be;
	} case_t;

	logic clk = 1'b0;
	logic rst_n;
	logic set_t;
	base_t t_base;
	logic t_valid;
	logic t_last;
	logic start_cal;
	logic [2*NUM_PE-1:0] s;
	logic [PE_LOG-1:0] s_len;
	logic [PEN_W-1:0] match;
	logic [PEN_W-1:0] mismatch;
	logic [PEN_W-1:0] alpha;
	logic [PEN_W-1:0] beta;
	logic busy;
	score_t result;
	logic valid;

	logic exp_go;
	logic exp_none;
	int exp_idx;
	int exp_score;
	int exp_bound;
	int chk_done;
	int chk_errors;
	int tb_errors;

	logic [31:0] seed;
	logic [2*MAX_T-1:0] cur_tgt;
	int cur_tlen;

	always #10 clk = ~clk;

	sw_top u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_set_t      (set_t),
		.i_t          (t_base),
		.i_t_valid    (t_valid),
		.i_t_last     (t_last),
		.i_start_cal  (start_cal),
		.i_s          (s),
		.i_s_len      (s_len),
		.i_match      (match),
		.i_mismatch   (mismatch),
		.i_minus_alpha(alpha),
		.i_minus_beta (beta),
		.o_busy       (busy),
		.o_result     (result),
		.o_valid      (valid)
	);

	sw_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_valid   (valid),
		.i_busy    (busy),
		.i_result  (result),
		.i_go      (exp_go),
		.i_none    (exp_none),
		.i_idx     (exp_idx),
		.i_expected(exp_score),
		.i_bound   (exp_bound),
		.o_done    (chk_done),
		.o_errors  (chk_errors)
	);

	function automatic case_t table_case(input int k);
		case (k)
			// identical target and query
			0: return '{1'b1, 1'b0, 128'hE4E4, 7'd8, 16'hE4E4, 4'd8, 4'd3, 4'd2, 4'd4, 4'd1};
			// nothing matches, floor at zero
			1: return '{1'b1, 1'b0, 128'h0, 7'd10, 16'hFFFF, 4'd8, 4'd5, 4'd3, 4'd4, 4'd2};
			// ACGT GG ACGT, one gap of two
			2: return '{1'b1, 1'b0, 128'hE4AE4, 7'd10, 16'hE4E4, 4'd8, 4'd4, 4'd4, 4'd3, 4'd1};
			3: return '{1'b0, 1'b0, 128'hE4AE4, 7'd10, 16'hE4E4, 4'd8, 4'd4, 4'd4, 4'd3, 4'd3};
			4: return '{1'b0, 1'b0, 128'hE4AE4, 7'd10, 16'hE4E4, 4'd8, 4'd4, 4'd4, 4'd6, 4'd1};
			// ACG ACGT, one base missing from the target
			5: return '{1'b1, 1'b0, 128'h3924, 7'd7, 16'hE4E4, 4'd8, 4'd4, 4'd4, 4'd2, 4'd1};
			6: return '{1'b1, 1'b0, 128'h1B6C_93E4_D827_A55A_0F3C_96E1_4BD2_7788, 7'd64,
				16'h0C9B, 4'd5, 4'd5, 4'd3, 4'd4, 4'd2};
			// penalty ports move during the run
			7: return '{1'b0, 1'b1, 128'h0, 7'd0, 16'h1B6C, 4'd8, 4'd6, 4'd2, 4'd3, 4'd1};
			default: return '0;
		endcase
	endfunction

	function automatic logic [31:0] lcg_step(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int imax(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// Gotoh recurrence, rows over the target and columns over the query
	function automatic int gotoh_score(input logic [2*MAX_T-1:0] tgt, input int tlen,
		input case_t c);
		int h_up [NUM_PE+1];
		int h_row [NUM_PE+1];
		int f_col [NUM_PE+1];
		int e;
		int d;
		int best;
		int ma;
		int mi;
		int al;
		int be;
		int qlen;
		ma = int'(c.ma);
		mi = int'(c.mi);
		al = int'(c.al);
		be = int'(c.be);
		qlen = int'(c.qlen);
		best = 0;
		for (int j = 0; j <= NUM_PE; j++) begin
			h_up[j] = 0;
			h_row[j] = 0;
			f_col[j] = NEG_INF;
		end
		for (int i = 0; i < tlen; i++) begin
			e = NEG_INF;
			for (int j = 1; j <= qlen; j++) begin
				e = imax(h_row[j-1] - al, e - be);
				f_col[j] = imax(h_up[j] - al, f_col[j] - be);
				d = h_up[j-1] + ((tgt[2*i +: 2] == c.q[2*(j-1) +: 2]) ? ma : -mi);
				h_row[j] = imax(imax(0, d), imax(e, f_col[j]));
				best = imax(best, h_row[j]);
			end
			h_up = h_row;
		end
		return best;
	endfunction

	task automatic random_case(output case_t c);
		c = '0;
		c.reload = 1'b1;
		for (int i = 0; i < 4; i++) begin
			seed = lcg_step(seed);
			c.tgt[32*i +: 32] = seed;
		end
		seed = lcg_step(seed);
		c.tlen = MAX_T_LOG'(seed[31:26]) + 1'b1;
		c.q = seed[23:8];
		seed = lcg_step(seed);
		c.qlen = PE_LOG'(seed[31:29]) + 1'b1;
		c.ma = seed[27:24];
		c.mi = seed[23:20];
		c.al = seed[19:16];
		c.be = seed[15:12];
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (busy && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("%0t ns: o_busy still high after %0d cycles", $time, limit);
			tb_errors++;
		end
	endtask

	task automatic load_target(input logic [2*MAX_T-1:0] tgt, input int tlen);
		@(negedge clk);
		set_t = 1'b1;
		@(negedge clk);
		set_t = 1'b0;
		for (int i = 0; i < tlen; i++) begin
			t_valid = 1'b1;
			t_base = tgt[2*i +: 2];
			t_last = (i == tlen - 1);
			@(negedge clk);
		end
		t_valid = 1'b0;
		t_last = 1'b0;
		wait_idle(tlen + 10);
	endtask

	task automatic arm_check(input int idx, input int score, input logic none, input int bound);
		exp_idx = idx;
		exp_score = score;
		exp_none = none;
		exp_bound = bound;
		exp_go = 1'b1;
	endtask

	task automatic run_case(input int idx, input case_t c);
		if (c.reload) begin
			cur_tgt = c.tgt;
			cur_tlen = int'(c.tlen);
			load_target(c.tgt, cur_tlen);
		end
		@(negedge clk);
		s = c.q;
		s_len = c.qlen;
		match = c.ma;
		mismatch = c.mi;
		alpha = c.al;
		beta = c.be;
		start_cal = 1'b1;
		arm_check(idx, gotoh_score(cur_tgt, cur_tlen, c), 1'b0, cur_tlen + NUM_PE + 16);
		@(negedge clk);
		start_cal = 1'b0;
		exp_go = 1'b0;
		if (c.pen_swap) begin
			repeat (2) @(negedge clk);
			match = ~c.ma;
			mismatch = ~c.mi;
			alpha = ~c.al;
			beta = ~c.be;
		end
		while (chk_done <= idx) begin
			@(negedge clk);
		end
		wait_idle(8);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run still going after %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		case_t c;
		seed = 32'h6e9c_700d;
		rst_n = 1'b0;
		set_t = 1'b0;
		t_base = '0;
		t_valid = 1'b0;
		t_last = 1'b0;
		start_cal = 1'b0;
		s = '0;
		s_len = '0;
		match = '0;
		mismatch = '0;
		alpha = '0;
		beta = '0;
		exp_go = 1'b0;
		exp_none = 1'b0;
		exp_idx = 0;
		exp_score = 0;
		exp_bound = 0;
		tb_errors = 0;
		cur_tgt = '0;
		cur_tlen = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// start before any target was loaded
		@(negedge clk);
		start_cal = 1'b1;
		arm_check(0, 0, 1'b1, 20);
		@(negedge clk);
		start_cal = 1'b0;
		exp_go = 1'b0;
		while (chk_done < 1) begin
			@(negedge clk);
		end

		for (int k = 0; k < N_TABLE; k++) begin
			run_case(k + 1, table_case(k));
		end
		for (int k = 0; k < N_RAND; k++) begin
			random_case(c);
			run_case(N_TABLE + 1 + k, c);
		end

		repeat (4) @(negedge clk);
		$display("tests run: %0d, errors: %0d", chk_done, chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sw_top.f
hw/sw_pkg.sv
hw/t_stream_if.sv
hw/t_buffer.sv
hw/pe_cell.sv
hw/pe_array.sv
hw/sw_top.sv
test/sw_props.sv
test/sw_checker.sv
test/sw_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, then look for the result line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module sw_tb -f sw_top.f -o sw_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sw_sim > sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; }
echo "FAIL: no result line in sim.log"
exit 1
